//--- mem_map_pkg.sv
`default_nettype none

package mem_map_pkg;

  typedef logic [7:0] byte_t;

  typedef enum logic [2:0] {
    rom_lo,
    rom_hi,
    bank0,
    bank1,
    work_ram
  } region_e;

  localparam int num_regions = 5;
  localparam int cpu_addr_w = 16;

  // address bits per region, in region_e order
  localparam int region_addr_w [num_regions] = '{15, 14, 13, 13, 13};

  // download image layout, work ram is not loaded
  localparam int num_dl_regions = 4;
  localparam int unsigned dl_base [num_dl_regions] = '{
    32'h0_0000,
    32'h0_8000,
    32'h0_c000,
    32'h0_e000
  };
  localparam int unsigned dl_end = 32'h1_0000;

  // cpu window start addresses
  localparam logic [cpu_addr_w-1:0] win_rom_hi = 16'h8000;
  localparam logic [cpu_addr_w-1:0] win_bank = 16'hc000;
  localparam logic [cpu_addr_w-1:0] win_spr = 16'he000;
  localparam logic [cpu_addr_w-1:0] win_ram = 16'he100;

endpackage

`default_nettype wire

//--- cpu_io_pkg.sv
`default_nettype none

package cpu_io_pkg;

  typedef enum logic [7:0] {
    in_j1 = 8'h00,
    in_j2 = 8'h01,
    in_system = 8'h02,
    in_p1 = 8'h03,
    in_p2 = 8'h04,
    ctl_bank_flip = 8'h40,
    scroll_x_lo = 8'h41,
    layers_scroll_x_hi = 8'h42,
    scroll_y_lo = 8'h43,
    scroll_y_hi = 8'h44,
    snd_cmd = 8'h45,
    irq_ack = 8'h46,
    board_id = 8'hc0
  } io_port_e;

  localparam logic [7:0] board_id_value = 8'h58;

  localparam int scroll_w = 11;
  localparam int layer_w = 3;

  typedef enum logic [1:0] {
    idle,
    mem_wait,
    done
  } bus_state_e;

endpackage

`default_nettype wire

//--- rom_loader.sv
`default_nettype none
`timescale 1ns/100ps

module rom_loader import mem_map_pkg::*; #(
  parameter int dl_addr_w = 27
) (
  input  logic                   clk_sys,
  input  logic                   arst_n,
  input  logic                   ioctl_download,
  input  logic                   ioctl_wr,
  input  logic [dl_addr_w-1:0]   ioctl_addr,
  input  logic [15:0]            ioctl_dout,
  output logic [num_regions-1:0] dl_we,
  output logic [14:0]            dl_addr,
  output byte_t                  dl_data
);

  logic [num_regions-1:0] hit;
  logic [dl_addr_w-1:0] off;

  // bases ascend, so the last base passed names the region
  always_comb begin
    hit = '0;
    off = '0;
    if (ioctl_download && ioctl_wr && ioctl_addr < dl_addr_w'(dl_end)) begin
      for (int r = 0; r < num_dl_regions; r++) begin
        if (ioctl_addr >= dl_addr_w'(dl_base[r])) begin
          hit = '0;
          hit[r] = 1'b1;
          off = ioctl_addr - dl_addr_w'(dl_base[r]);
        end
      end
    end
  end

  always_ff @(posedge clk_sys or negedge arst_n) begin
    if (!arst_n) begin
      dl_we <= '0;
    end else begin
      dl_we <= hit;
    end
  end

  // only the low byte of the download word carries data
  always_ff @(posedge clk_sys) begin
    dl_addr <= off[14:0];
    dl_data <= ioctl_dout[7:0];
  end

endmodule

`default_nettype wire

//--- memory_region.sv
`default_nettype none
`timescale 1ns/100ps

module memory_region import mem_map_pkg::*; #(
  parameter int addr_w = 13
) (
  input  logic              clk_sys,
  input  logic              dl_we,
  input  logic [addr_w-1:0] dl_addr,
  input  byte_t             dl_data,
  input  logic [addr_w-1:0] cpu_addr,
  input  logic              cpu_we,
  input  byte_t             cpu_wdata,
  output byte_t             rdata
);

  byte_t mem [2**addr_w];

  // port a for the loader, port b for the bus
  always_ff @(posedge clk_sys) begin
    if (dl_we) begin
      mem[dl_addr] <= dl_data;
    end
    if (cpu_we) begin
      mem[cpu_addr] <= cpu_wdata;
    end
    rdata <= mem[cpu_addr];
  end

endmodule

`default_nettype wire

//--- main_bus_apb.sv
`default_nettype none
`timescale 1ns/100ps

module main_bus_apb import mem_map_pkg::*, cpu_io_pkg::*; (
  input  logic                    clk_sys,
  input  logic                    arst_n,
  input  logic                    psel,
  input  logic                    penable,
  input  logic                    pwrite,
  input  logic [cpu_addr_w:0]     paddr,
  input  byte_t                   pwdata,
  output byte_t                   prdata,
  output logic                    pready,
  output logic [cpu_addr_w-1:0]   cpu_addr,
  output byte_t                   cpu_wdata,
  output logic                    ram_we,
  input  byte_t [num_regions-1:0] region_rdata,
  input  logic                    bank,
  output logic                    io_sel,
  output logic                    io_we,
  output io_port_e                io_port,
  output byte_t                   io_wdata,
  input  byte_t                   io_rdata
);

  bus_state_e state;
  bus_state_e state_nxt;
  logic is_io;
  logic in_spr;
  logic in_ram;
  region_e rd_region;

  // bit 16 splits i/o space from memory
  assign is_io = paddr[cpu_addr_w];
  assign cpu_addr = paddr[cpu_addr_w-1:0];

  always_comb begin
    rd_region = work_ram;
    in_spr = 1'b0;
    if (cpu_addr < win_rom_hi) begin
      rd_region = rom_lo;
    end else if (cpu_addr < win_bank) begin
      rd_region = rom_hi;
    end else if (cpu_addr < win_spr) begin
      rd_region = bank ? bank1 : bank0;
    end else if (cpu_addr < win_ram) begin
      // sprite ram lives with the video side
      in_spr = 1'b1;
    end
  end

  assign in_ram = !in_spr && rd_region == work_ram;

  // setup cycle starts the count, memory waits one extra cycle
  always_comb begin
    state_nxt = state;
    case (state)
      idle: begin
        if (psel && !penable) begin
          state_nxt = is_io ? done : mem_wait;
        end
      end
      mem_wait: state_nxt = done;
      done: state_nxt = idle;
      default: state_nxt = idle;
    endcase
  end

  always_ff @(posedge clk_sys or negedge arst_n) begin
    if (!arst_n) begin
      state <= idle;
    end else begin
      state <= state_nxt;
    end
  end

  assign pready = state == done;

  // writes land on the pready edge
  assign cpu_wdata = pwdata;
  assign ram_we = pready && pwrite && !is_io && in_ram;

  assign io_sel = pready && is_io;
  assign io_we = psel && pwrite;
  assign io_port = io_port_e'(paddr[7:0]);
  assign io_wdata = pwdata;

  always_comb begin
    if (is_io) begin
      prdata = io_rdata;
    end else if (in_spr) begin
      prdata = 8'h00;
    end else begin
      prdata = region_rdata[rd_region];
    end
  end

endmodule

`default_nettype wire

//--- io_ports.sv
`default_nettype none
`timescale 1ns/100ps

module io_ports import mem_map_pkg::*, cpu_io_pkg::*; (
  input  logic                clk_sys,
  input  logic                arst_n,
  input  logic                io_sel,
  input  logic                io_we,
  input  io_port_e            io_port,
  input  byte_t               io_wdata,
  output byte_t               io_rdata,
  input  byte_t               j1,
  input  byte_t               j2,
  input  byte_t               p1,
  input  byte_t               p2,
  input  byte_t               system,
  input  logic                vs,
  input  logic                snd_clear,
  output logic [scroll_w-1:0] scroll_x,
  output logic [scroll_w-1:0] scroll_y,
  output logic [layer_w-1:0]  layers,
  output logic                flip,
  output logic                bank,
  output logic                irq,
  output byte_t               snd_latch
);

  logic wr;
  logic vs_q;

  assign wr = io_sel && io_we;

  always_comb begin
    case (io_port)
      in_j1: io_rdata = j1;
      in_j2: io_rdata = j2;
      in_system: io_rdata = system;
      in_p1: io_rdata = p1;
      in_p2: io_rdata = p2;
      board_id: io_rdata = board_id_value;
      default: io_rdata = 8'h00;
    endcase
  end

  always_ff @(posedge clk_sys or negedge arst_n) begin
    if (!arst_n) begin
      scroll_x <= '0;
      scroll_y <= '0;
      layers <= '0;
      flip <= 1'b0;
      bank <= 1'b0;
      snd_latch <= '0;
    end else begin
      // audio side clears, a command in the same cycle overrides
      if (snd_clear) begin
        snd_latch <= '0;
      end
      if (wr) begin
        case (io_port)
          ctl_bank_flip: begin
            bank <= io_wdata[7];
            flip <= io_wdata[2];
          end
          scroll_x_lo: scroll_x[7:0] <= io_wdata;
          layers_scroll_x_hi: begin
            layers <= io_wdata[7:8-layer_w];
            scroll_x[scroll_w-1:8] <= io_wdata[scroll_w-9:0];
          end
          scroll_y_lo: scroll_y[7:0] <= io_wdata;
          scroll_y_hi: scroll_y[scroll_w-1:8] <= io_wdata[scroll_w-9:0];
          snd_cmd: snd_latch <= {io_wdata[6:0], 1'b1};
          default: ;
        endcase
      end
    end
  end

  // vblank start is the falling edge of vs
  always_ff @(posedge clk_sys or negedge arst_n) begin
    if (!arst_n) begin
      vs_q <= 1'b0;
      irq <= 1'b0;
    end else begin
      vs_q <= vs;
      if (wr && io_port == irq_ack) begin
        irq <= 1'b0;
      end
      if (vs_q && !vs) begin
        irq <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- main_board.sv
`default_nettype none
`timescale 1ns/100ps

module main_board import mem_map_pkg::*, cpu_io_pkg::*; #(
  parameter int dl_addr_w = 27
) (
  input  logic                clk_sys,
  input  logic                arst_n,
  input  logic                psel,
  input  logic                penable,
  input  logic                pwrite,
  input  logic [16:0]         paddr,
  input  byte_t               pwdata,
  output byte_t               prdata,
  output logic                pready,
  input  logic                ioctl_download,
  input  logic                ioctl_wr,
  input  logic [dl_addr_w-1:0] ioctl_addr,
  input  logic [15:0]         ioctl_dout,
  input  byte_t               j1,
  input  byte_t               j2,
  input  byte_t               p1,
  input  byte_t               p2,
  input  byte_t               system,
  input  logic                vs,
  input  logic                snd_clear,
  output logic [scroll_w-1:0] scroll_x,
  output logic [scroll_w-1:0] scroll_y,
  output logic [layer_w-1:0]  layers,
  output logic                flip,
  output byte_t               snd_latch,
  output logic                irq
);

  logic [num_regions-1:0] dl_we;
  logic [14:0] dl_addr;
  byte_t dl_data;
  logic [cpu_addr_w-1:0] cpu_addr;
  byte_t cpu_wdata;
  logic ram_we;
  byte_t [num_regions-1:0] region_rdata;
  logic bank;
  logic io_sel;
  logic io_we;
  io_port_e io_port;
  byte_t io_wdata;
  byte_t io_rdata;

  rom_loader #(
    .dl_addr_w(dl_addr_w)
  ) rom_loader_inst (
    .clk_sys(clk_sys),
    .arst_n(arst_n),
    .ioctl_download(ioctl_download),
    .ioctl_wr(ioctl_wr),
    .ioctl_addr(ioctl_addr),
    .ioctl_dout(ioctl_dout),
    .dl_we(dl_we),
    .dl_addr(dl_addr),
    .dl_data(dl_data)
  );

  // roms keep the bus write port tied off
  for (genvar i = 0; i < num_regions; i++) begin : g_region
    memory_region #(
      .addr_w(region_addr_w[i])
    ) region_inst (
      .clk_sys(clk_sys),
      .dl_we(dl_we[i]),
      .dl_addr(dl_addr[region_addr_w[i]-1:0]),
      .dl_data(dl_data),
      .cpu_addr(cpu_addr[region_addr_w[i]-1:0]),
      .cpu_we(i == work_ram ? ram_we : 1'b0),
      .cpu_wdata(cpu_wdata),
      .rdata(region_rdata[i])
    );
  end

  main_bus_apb main_bus_apb_inst (
    .clk_sys(clk_sys),
    .arst_n(arst_n),
    .psel(psel),
    .penable(penable),
    .pwrite(pwrite),
    .paddr(paddr),
    .pwdata(pwdata),
    .prdata(prdata),
    .pready(pready),
    .cpu_addr(cpu_addr),
    .cpu_wdata(cpu_wdata),
    .ram_we(ram_we),
    .region_rdata(region_rdata),
    .bank(bank),
    .io_sel(io_sel),
    .io_we(io_we),
    .io_port(io_port),
    .io_wdata(io_wdata),
    .io_rdata(io_rdata)
  );

  io_ports io_ports_inst (
    .clk_sys(clk_sys),
    .arst_n(arst_n),
    .io_sel(io_sel),
    .io_we(io_we),
    .io_port(io_port),
    .io_wdata(io_wdata),
    .io_rdata(io_rdata),
    .j1(j1),
    .j2(j2),
    .p1(p1),
    .p2(p2),
    .system(system),
    .vs(vs),
    .snd_clear(snd_clear),
    .scroll_x(scroll_x),
    .scroll_y(scroll_y),
    .layers(layers),
    .flip(flip),
    .bank(bank),
    .irq(irq),
    .snd_latch(snd_latch)
  );

endmodule

`default_nettype wire

//--- main_board_tb.sv
`default_nettype none
`timescale 1ns/100ps

module main_board_tb import mem_map_pkg::*, cpu_io_pkg::*; ();

  localparam int dl_addr_w = 27;
  localparam int clk_period = 40;
  localparam int drive_dly = 2;
  localparam int reset_cycles = 4;
  localparam int max_waits = 4;

  // twice the rough cycle cost of the whole run
  localparam int apb_ops = 60;
  localparam int apb_op_cycles = 5;
  localparam int dl_ops = 20;
  localparam int dl_op_cycles = 2;
  localparam int misc_cycles = 20;
  localparam int watchdog_ns = 2 * clk_period *
    (reset_cycles + apb_ops * apb_op_cycles + dl_ops * dl_op_cycles + misc_cycles);

  // download image layout and where each part shows up on the cpu bus
  localparam logic [26:0] dl_start [4] = '{27'h0000, 27'h8000, 27'hc000, 27'he000};
  localparam logic [15:0] cpu_start [4] = '{16'h0000, 16'h8000, 16'hc000, 16'hc000};
  localparam int region_size [4] = '{'h8000, 'h4000, 'h2000, 'h2000};

  logic clk_sys;
  logic arst_n;
  logic psel;
  logic penable;
  logic pwrite;
  logic [16:0] paddr;
  byte_t pwdata;
  byte_t prdata;
  logic pready;
  logic ioctl_download;
  logic ioctl_wr;
  logic [dl_addr_w-1:0] ioctl_addr;
  logic [15:0] ioctl_dout;
  byte_t j1;
  byte_t j2;
  byte_t p1;
  byte_t p2;
  byte_t system;
  logic vs;
  logic snd_clear;
  logic [10:0] scroll_x;
  logic [10:0] scroll_y;
  logic [2:0] layers;
  logic flip;
  byte_t snd_latch;
  logic irq;

  logic [31:0] lfsr_state;
  int err_count;
  int dl_off [4][4];
  byte_t dl_val [4][4];

  main_board #(
    .dl_addr_w(dl_addr_w)
  ) main_board_inst (.*);

  initial clk_sys = 1'b0;
  always #(clk_period / 2) clk_sys = ~clk_sys;

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
  endtask

  task automatic rand_byte(output byte_t b);
    logic [31:0] v;
    rand_bits(8, v);
    b = v[7:0];
  endtask

  function automatic logic [16:0] io_addr(input byte_t port);
    return {9'h100, port};
  endfunction

  function automatic logic [16:0] mem_addr(input logic [15:0] a);
    return {1'b0, a};
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      err_count++;
      $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
      $display("Errors found");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  task automatic apb_access(input logic write, input logic [16:0] addr, input byte_t wdata,
                            output byte_t rdata, output int waits);
    @(posedge clk_sys);
    #(drive_dly);
    psel = 1'b1;
    penable = 1'b0;
    pwrite = write;
    paddr = addr;
    pwdata = wdata;
    @(posedge clk_sys);
    #(drive_dly);
    penable = 1'b1;
    waits = 0;
    @(negedge clk_sys);
    while (!pready && waits < max_waits) begin
      waits++;
      @(negedge clk_sys);
    end
    if (!pready) begin
      $display("no pready from the DUT within %0d wait states, paddr 0x%05h", max_waits, addr);
      $display("Errors found");
      $fatal(1, "bus access did not complete");
    end else begin
      rdata = prdata;
      @(posedge clk_sys);
      #(drive_dly);
      psel = 1'b0;
      penable = 1'b0;
      pwrite = 1'b0;
    end
  endtask

  task automatic write_bus(input logic [16:0] addr, input byte_t data);
    byte_t unused;
    int waits;
    apb_access(1'b1, addr, data, unused, waits);
  endtask

  // io ports answer at once and memory adds one wait state
  task automatic read_expect(input logic [16:0] addr, input byte_t exp, input int exp_waits);
    byte_t data;
    int waits;
    apb_access(1'b0, addr, 8'h00, data, waits);
    check($sformatf("prdata @0x%05h", addr), data, exp);
    check($sformatf("pready wait count @0x%05h", addr), waits, exp_waits);
  endtask

  task automatic download_byte(input logic [26:0] addr, input byte_t data);
    @(posedge clk_sys);
    #(drive_dly);
    ioctl_wr = 1'b1;
    ioctl_addr = addr;
    ioctl_dout = {~data, data};
    @(posedge clk_sys);
    #(drive_dly);
    ioctl_wr = 1'b0;
  endtask

  task automatic reset_values();
    check("pready", pready, 1'b0);
    check("irq", irq, 1'b0);
    check("flip", flip, 1'b0);
    check("scroll_x", scroll_x, 11'h000);
    check("scroll_y", scroll_y, 11'h000);
    check("layers", layers, 3'h0);
    check("snd_latch", snd_latch, 8'h00);
    read_expect(io_addr(8'h80), 8'h00, 0);
    read_expect(mem_addr(16'he000), 8'h00, 1);
  endtask

  task automatic download_readback();
    logic [31:0] r;
    ioctl_download = 1'b1;
    for (int rg = 0; rg < 4; rg++) begin
      rand_bits(16, r);
      dl_off[rg][0] = 0;
      dl_off[rg][1] = 1;
      dl_off[rg][2] = 2 + int'(r % (region_size[rg] - 3));
      dl_off[rg][3] = region_size[rg] - 1;
      for (int k = 0; k < 4; k++) begin
        rand_byte(dl_val[rg][k]);
        download_byte(dl_start[rg] + 27'(dl_off[rg][k]), dl_val[rg][k]);
      end
    end
    // past the end of the image nothing lands
    // byte differs from the rom_lo and bank1 bytes at offset 0
    download_byte(27'h1_0000, {~dl_val[0][0][7:4], ~dl_val[3][0][3:0]});
    ioctl_download = 1'b0;
    write_bus(io_addr(ctl_bank_flip), 8'h00);
    for (int rg = 0; rg < 3; rg++) begin
      for (int k = 0; k < 4; k++) begin
        read_expect(mem_addr(cpu_start[rg] + 16'(dl_off[rg][k])), dl_val[rg][k], 1);
      end
    end
    write_bus(io_addr(ctl_bank_flip), 8'h80);
    for (int k = 0; k < 4; k++) begin
      read_expect(mem_addr(cpu_start[3] + 16'(dl_off[3][k])), dl_val[3][k], 1);
    end
  endtask

  task automatic work_ram_access();
    logic [31:0] r;
    logic [15:0] addrs [4];
    byte_t vals [4];
    rand_bits(16, r);
    addrs = '{16'he100, 16'he101, 16'he102 + 16'(r % 32'h1efd), 16'hffff};
    for (int k = 0; k < 4; k++) begin
      rand_byte(vals[k]);
      write_bus(mem_addr(addrs[k]), vals[k]);
    end
    for (int k = 0; k < 4; k++) begin
      read_expect(mem_addr(addrs[k]), vals[k], 1);
    end
    write_bus(mem_addr(cpu_start[0] + 16'(dl_off[0][2])), ~dl_val[0][2]);
    read_expect(mem_addr(cpu_start[0] + 16'(dl_off[0][2])), dl_val[0][2], 1);
    write_bus(mem_addr(16'he000), 8'hff);
    read_expect(mem_addr(16'he000), 8'h00, 1);
  endtask

  task automatic io_port_access();
    byte_t d;
    byte_t lo_x;
    byte_t hi_x;
    byte_t lo_y;
    byte_t hi_y;
    @(posedge clk_sys);
    #(drive_dly);
    rand_byte(j1);
    rand_byte(j2);
    rand_byte(system);
    rand_byte(p1);
    rand_byte(p2);
    read_expect(io_addr(in_j1), j1, 0);
    read_expect(io_addr(in_j2), j2, 0);
    read_expect(io_addr(in_system), system, 0);
    read_expect(io_addr(in_p1), p1, 0);
    read_expect(io_addr(in_p2), p2, 0);
    read_expect(io_addr(board_id), 8'h58, 0);
    rand_byte(d);
    for (int n = 0; n < 2; n++) begin
      write_bus(io_addr(ctl_bank_flip), d);
      check("flip", flip, d[2]);
      // bank is seen through which image the banked window returns
      read_expect(mem_addr(16'hc000), d[7] ? dl_val[3][0] : dl_val[2][0], 1);
      d = d ^ 8'h84;
    end
    rand_byte(lo_x);
    rand_byte(hi_x);
    rand_byte(lo_y);
    rand_byte(hi_y);
    write_bus(io_addr(scroll_x_lo), lo_x);
    write_bus(io_addr(layers_scroll_x_hi), hi_x);
    write_bus(io_addr(scroll_y_lo), lo_y);
    write_bus(io_addr(scroll_y_hi), hi_y);
    check("scroll_x", scroll_x, {hi_x[2:0], lo_x});
    check("layers", layers, hi_x[7:5]);
    check("scroll_y", scroll_y, {hi_y[2:0], lo_y});
  endtask

  task automatic sound_and_irq();
    byte_t d;
    rand_byte(d);
    write_bus(io_addr(snd_cmd), d);
    check("snd_latch", snd_latch, {d[6:0], 1'b1});
    @(posedge clk_sys);
    #(drive_dly);
    snd_clear = 1'b1;
    @(posedge clk_sys);
    #(drive_dly);
    snd_clear = 1'b0;
    check("snd_latch", snd_latch, 8'h00);
    check("irq", irq, 1'b0);
    vs = 1'b1;
    repeat (2) @(posedge clk_sys);
    #(drive_dly);
    vs = 1'b0;
    check("irq", irq, 1'b0);
    @(posedge clk_sys);
    #(drive_dly);
    check("irq", irq, 1'b1);
    write_bus(io_addr(irq_ack), 8'h00);
    check("irq", irq, 1'b0);
  endtask

  initial begin
    #(watchdog_ns);
    $display("watchdog: run went past %0d ns without finishing", watchdog_ns);
    $display("Errors found");
    $fatal(1, "timeout");
  end

  initial begin
    err_count = 0;
    lfsr_state = 32'h96ee_810c;
    arst_n = 1'b0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = 8'h00;
    ioctl_download = 1'b0;
    ioctl_wr = 1'b0;
    ioctl_addr = '0;
    ioctl_dout = 16'h0000;
    j1 = 8'h00;
    j2 = 8'h00;
    p1 = 8'h00;
    p2 = 8'h00;
    system = 8'h00;
    vs = 1'b0;
    snd_clear = 1'b0;
    repeat (reset_cycles) @(posedge clk_sys);
    #(drive_dly);
    arst_n = 1'b1;
    reset_values();
    download_readback();
    work_ram_access();
    io_port_access();
    sound_and_irq();
    if (err_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- main_board.f
mem_map_pkg.sv
cpu_io_pkg.sv
rom_loader.sv
memory_region.sv
main_bus_apb.sv
io_ports.sv
main_board.sv
main_board_tb.sv

//--- run.sh
#!/bin/sh
# build and run the main board testbench with verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
  -f main_board.f \
  --top-module main_board_tb \
  -o main_board_sim

./obj_dir/main_board_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "No errors" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
